// File: hw/z8Pkg.sv
`default_nettype none

package z8Pkg;

    typedef logic [7:0] byteT;
    typedef logic [15:0] addrT;

    // same bit order as register FC
    typedef struct packed {
        logic       c;
        logic       z;
        logic       s;
        logic       v;
        logic [3:0] zero;
    } flagsT;

    // add..xor match the high nibble of column 2
    typedef enum logic [3:0] {
        aluAdd = 4'h0,
        aluAdc = 4'h1,
        aluSub = 4'h2,
        aluSbc = 4'h3,
        aluOr  = 4'h4,
        aluAnd = 4'h5,
        aluTcm = 4'h6,
        aluTm  = 4'h7,
        aluCp  = 4'hA,
        aluXor = 4'hB,
        aluInc = 4'hE,
        aluLd  = 4'hF
    } aluOpT;

    // low opcode nibble
    typedef enum logic [3:0] {
        colAlu2 = 4'h2,
        colLdR  = 4'h6,
        colJr   = 4'hB,
        colLdr  = 4'hC,
        colJp   = 4'hD,
        colInc  = 4'hE,
        colMisc = 4'hF
    } instrColT;

    localparam byteT regFlags = 8'hFC;
    localparam byteT regPort2 = 8'h02;

    // carry control commands
    localparam logic [1:0] carryKeep   = 2'd0;
    localparam logic [1:0] carryClear  = 2'd1;
    localparam logic [1:0] carrySet    = 2'd2;
    localparam logic [1:0] carryToggle = 2'd3;

endpackage

`default_nettype wire

// File: hw/programMemory.sv
`timescale 1ns/1ps
`default_nettype none

module programMemory #(
    parameter int addrWidth = 8
) (
    input  logic                 clk,
    input  logic [addrWidth-1:0] addr,
    input  logic                 strobe,
    input  logic                 loadWrite,
    input  logic [addrWidth-1:0] loadAddr,
    input  z8Pkg::byteT          loadData,
    output z8Pkg::byteT          data
);

    z8Pkg::byteT mem [0:(1 << addrWidth) - 1];

    // loader wins over a fetch
    always_ff @(posedge clk) begin
        if (loadWrite) begin
            mem[loadAddr] <= loadData;
        end else if (strobe) begin
            data <= mem[addr];
        end
    end

endmodule

`default_nettype wire

// File: hw/fetchUnit.sv
`timescale 1ns/1ps
`default_nettype none

module fetchUnit (
    input  logic        clk,
    input  logic        rst,
    input  z8Pkg::byteT memData,
    input  logic        captureByte,
    input  logic [1:0]  byteIndex,
    input  logic        loadPc,
    input  logic        addRelative,
    output z8Pkg::addrT fetchAddr,
    output z8Pkg::byteT opcode,
    output z8Pkg::byteT second,
    output z8Pkg::byteT third,
    output logic [1:0]  length
);

    z8Pkg::addrT pc;
    z8Pkg::byteT headByte;

    assign fetchAddr = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (captureByte) begin
            pc <= pc + 16'd1;
        end else if (loadPc) begin
            pc <= {second, third};
        end else if (addRelative) begin
            pc <= pc + {{8{second[7]}}, second};
        end
    end

    always_ff @(posedge clk) begin
        if (captureByte) begin
            case (byteIndex)
                2'd0:    opcode <= memData;
                2'd1:    second <= memData;
                default: third <= memData;
            endcase
        end
    end

    // opcode bypass so the sequencer knows the length while capturing byte 0
    assign headByte = (captureByte && byteIndex == 2'd0) ? memData : opcode;

    always_comb begin
        case (z8Pkg::instrColT'(headByte[3:0]))
            z8Pkg::colInc,
            z8Pkg::colMisc: length = 2'd1;
            z8Pkg::colLdR,
            z8Pkg::colJp:   length = 2'd3;
            default:        length = 2'd2;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile (
    input  logic         clk,
    input  logic         rst,
    input  z8Pkg::byteT  readAddrA,
    input  z8Pkg::byteT  readAddrB,
    output z8Pkg::byteT  dataA,
    output z8Pkg::byteT  dataB,
    input  logic         regWrite,
    input  z8Pkg::byteT  writeAddr,
    input  z8Pkg::byteT  writeData,
    input  logic         flagsWrite,
    input  z8Pkg::flagsT flagsIn,
    input  logic [1:0]   carryCmd,
    output z8Pkg::flagsT flags,
    output z8Pkg::byteT  port2,
    output logic         port2Write
);

    z8Pkg::byteT regs [0:127];

    function automatic z8Pkg::byteT readReg(input z8Pkg::byteT addr);
        if (!addr[7]) begin
            return regs[addr[6:0]];
        end else if (addr == z8Pkg::regFlags) begin
            return flags;
        end
        return '0;
    endfunction

    always_comb begin
        dataA = readReg(readAddrA);
        dataB = readReg(readAddrB);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 128; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite && !writeAddr[7]) begin
            regs[writeAddr[6:0]] <= writeData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            flags <= '0;
        end else if (regWrite && writeAddr == z8Pkg::regFlags) begin
            // low nibble always reads 0
            flags <= z8Pkg::flagsT'({writeData[7:4], 4'h0});
        end else if (flagsWrite) begin
            flags <= flagsIn;
        end else begin
            case (carryCmd)
                z8Pkg::carryClear:  flags.c <= 1'b0;
                z8Pkg::carrySet:    flags.c <= 1'b1;
                z8Pkg::carryToggle: flags.c <= ~flags.c;
                default:            flags.c <= flags.c;
            endcase
        end
    end

    // port 2 is register 02
    assign port2 = regs[2];
    assign port2Write = regWrite && (writeAddr == z8Pkg::regPort2);

endmodule

`default_nettype wire

// File: hw/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  z8Pkg::aluOpT op,
    input  z8Pkg::byteT  a,
    input  z8Pkg::byteT  b,
    input  z8Pkg::flagsT flags,
    input  logic [3:0]   cond,
    output z8Pkg::byteT  result,
    output z8Pkg::flagsT flagsOut,
    output logic         takeBranch
);

    logic [8:0] wide;
    logic       carryIn;
    logic       condMet;

    always_comb begin
        wide = '0;
        result = b;
        flagsOut = flags;
        carryIn = flags.c && (op == z8Pkg::aluAdc || op == z8Pkg::aluSbc);
        case (op)
            z8Pkg::aluAdd,
            z8Pkg::aluAdc: begin
                wide = {1'b0, a} + {1'b0, b} + {8'h00, carryIn};
                result = wide[7:0];
                flagsOut.c = wide[8];
                flagsOut.v = (a[7] == b[7]) && (result[7] != a[7]);
            end
            z8Pkg::aluSub,
            z8Pkg::aluSbc,
            z8Pkg::aluCp: begin
                // carry holds the borrow
                wide = {1'b0, a} - {1'b0, b} - {8'h00, carryIn};
                result = wide[7:0];
                flagsOut.c = wide[8];
                flagsOut.v = (a[7] != b[7]) && (result[7] != a[7]);
            end
            z8Pkg::aluOr: begin
                result = a | b;
                flagsOut.v = 1'b0;
            end
            z8Pkg::aluAnd,
            z8Pkg::aluTm: begin
                result = a & b;
                flagsOut.v = 1'b0;
            end
            z8Pkg::aluTcm: begin
                result = ~a & b;
                flagsOut.v = 1'b0;
            end
            z8Pkg::aluXor: begin
                result = a ^ b;
                flagsOut.v = 1'b0;
            end
            z8Pkg::aluInc: begin
                result = a + 8'h01;
                flagsOut.v = (a == 8'h7F);
            end
            default: begin
                result = b;
            end
        endcase
        if (op != z8Pkg::aluLd) begin
            flagsOut.z = (result == 8'h00);
            flagsOut.s = result[7];
        end
    end

    // upper half of the table is the inverse
    always_comb begin
        case (cond[2:0])
            3'd0: condMet = 1'b0;
            3'd1: condMet = flags.s ^ flags.v;
            3'd2: condMet = (flags.s ^ flags.v) | flags.z;
            3'd3: condMet = flags.c | flags.z;
            3'd4: condMet = flags.v;
            3'd5: condMet = flags.s;
            3'd6: condMet = flags.z;
            default: condMet = flags.c;
        endcase
    end

    assign takeBranch = condMet ^ cond[3];

endmodule

`default_nettype wire

// File: hw/sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module sequencer (
    input  logic         clk,
    input  logic         rst,
    input  z8Pkg::byteT  opcode,
    input  z8Pkg::byteT  second,
    input  z8Pkg::byteT  third,
    input  logic [1:0]   length,
    input  logic         takeBranch,
    output logic         memStrobe,
    output logic         captureByte,
    output logic [1:0]   byteIndex,
    output logic         loadPc,
    output logic         addRelative,
    output z8Pkg::byteT  readAddrA,
    output z8Pkg::byteT  readAddrB,
    output z8Pkg::aluOpT aluOp,
    output z8Pkg::byteT  immediate,
    output logic         useImmediate,
    output logic         regWrite,
    output z8Pkg::byteT  writeAddr,
    output logic         flagsWrite,
    output logic [1:0]   carryCmd
);

    typedef enum logic [1:0] {
        stIdle,
        stFetch,
        stCapture,
        stExecute
    } stateT;

    stateT      state;
    logic [3:0] hi;
    logic       execute;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stIdle;
            byteIndex <= 2'd0;
        end else begin
            case (state)
                stIdle:  state <= stFetch;
                stFetch: state <= stCapture;
                stCapture: begin
                    if (byteIndex == length - 2'd1) begin
                        state <= stExecute;
                        byteIndex <= 2'd0;
                    end else begin
                        state <= stFetch;
                        byteIndex <= byteIndex + 2'd1;
                    end
                end
                default: state <= stFetch;
            endcase
        end
    end

    assign memStrobe = (state == stFetch);
    assign captureByte = (state == stCapture);
    assign execute = (state == stExecute);
    assign hi = opcode[7:4];

    always_comb begin
        readAddrA = {4'h0, second[7:4]};
        readAddrB = {4'h0, second[3:0]};
        aluOp = z8Pkg::aluLd;
        immediate = second;
        useImmediate = 1'b0;
        regWrite = 1'b0;
        writeAddr = {4'h0, second[7:4]};
        flagsWrite = 1'b0;
        carryCmd = z8Pkg::carryKeep;
        loadPc = 1'b0;
        addRelative = 1'b0;
        if (execute) begin
            case (z8Pkg::instrColT'(opcode[3:0]))
                z8Pkg::colAlu2: begin
                    // lde/ldc rows fall through as nop
                    if (hi <= 4'h7 || hi == 4'hA || hi == 4'hB) begin
                        aluOp = z8Pkg::aluOpT'(hi);
                        flagsWrite = 1'b1;
                        regWrite = (hi[3:2] == 2'b00) || (hi[3:1] == 3'b010)
                                   || (hi == 4'hB);
                    end
                end
                z8Pkg::colLdr: begin
                    useImmediate = 1'b1;
                    regWrite = 1'b1;
                    writeAddr = {4'h0, hi};
                end
                z8Pkg::colLdR: begin
                    if (hi == 4'hE) begin
                        immediate = third;
                        useImmediate = 1'b1;
                        regWrite = 1'b1;
                        // Ex names working register x
                        writeAddr = (second[7:4] == 4'hE) ? {4'h0, second[3:0]} : second;
                    end
                end
                z8Pkg::colJr: addRelative = takeBranch;
                z8Pkg::colJp: loadPc = takeBranch;
                z8Pkg::colInc: begin
                    readAddrA = {4'h0, hi};
                    aluOp = z8Pkg::aluInc;
                    regWrite = 1'b1;
                    flagsWrite = 1'b1;
                    writeAddr = {4'h0, hi};
                end
                z8Pkg::colMisc: begin
                    case (hi)
                        4'hC:    carryCmd = z8Pkg::carryClear;
                        4'hD:    carryCmd = z8Pkg::carrySet;
                        4'hE:    carryCmd = z8Pkg::carryToggle;
                        default: carryCmd = z8Pkg::carryKeep;
                    endcase
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/z8Soc.sv
`timescale 1ns/1ps
`default_nettype none

module z8Soc #(
    parameter int romAddrWidth = 8
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    loadWrite,
    input  logic [romAddrWidth-1:0] loadAddr,
    input  z8Pkg::byteT             loadData,
    output z8Pkg::byteT             port2,
    output logic                    port2Write
);

    logic         memStrobe;
    z8Pkg::byteT  memData;
    z8Pkg::addrT  fetchAddr;
    logic         captureByte;
    logic [1:0]   byteIndex;
    logic         loadPc;
    logic         addRelative;
    z8Pkg::byteT  opcode;
    z8Pkg::byteT  second;
    z8Pkg::byteT  third;
    logic [1:0]   length;
    z8Pkg::byteT  readAddrA;
    z8Pkg::byteT  readAddrB;
    z8Pkg::byteT  dataA;
    z8Pkg::byteT  dataB;
    z8Pkg::aluOpT aluOp;
    z8Pkg::byteT  immediate;
    logic         useImmediate;
    z8Pkg::byteT  aluB;
    logic         regWrite;
    z8Pkg::byteT  writeAddr;
    logic         flagsWrite;
    logic [1:0]   carryCmd;
    z8Pkg::flagsT flags;
    z8Pkg::byteT  result;
    z8Pkg::flagsT flagsOut;
    logic         takeBranch;

    // immediate loads bypass the second read port
    assign aluB = useImmediate ? immediate : dataB;

    programMemory #(
        .addrWidth(romAddrWidth)
    ) u_programMemory (
        .clk(clk),
        .addr(fetchAddr[romAddrWidth-1:0]),
        .strobe(memStrobe),
        .loadWrite(loadWrite),
        .loadAddr(loadAddr),
        .loadData(loadData),
        .data(memData)
    );

    fetchUnit u_fetchUnit (
        .clk(clk),
        .rst(rst),
        .memData(memData),
        .captureByte(captureByte),
        .byteIndex(byteIndex),
        .loadPc(loadPc),
        .addRelative(addRelative),
        .fetchAddr(fetchAddr),
        .opcode(opcode),
        .second(second),
        .third(third),
        .length(length)
    );

    registerFile u_registerFile (
        .clk(clk),
        .rst(rst),
        .readAddrA(readAddrA),
        .readAddrB(readAddrB),
        .dataA(dataA),
        .dataB(dataB),
        .regWrite(regWrite),
        .writeAddr(writeAddr),
        .writeData(result),
        .flagsWrite(flagsWrite),
        .flagsIn(flagsOut),
        .carryCmd(carryCmd),
        .flags(flags),
        .port2(port2),
        .port2Write(port2Write)
    );

    alu u_alu (
        .op(aluOp),
        .a(dataA),
        .b(aluB),
        .flags(flags),
        .cond(opcode[7:4]),
        .result(result),
        .flagsOut(flagsOut),
        .takeBranch(takeBranch)
    );

    sequencer u_sequencer (
        .clk(clk),
        .rst(rst),
        .opcode(opcode),
        .second(second),
        .third(third),
        .length(length),
        .takeBranch(takeBranch),
        .memStrobe(memStrobe),
        .captureByte(captureByte),
        .byteIndex(byteIndex),
        .loadPc(loadPc),
        .addRelative(addRelative),
        .readAddrA(readAddrA),
        .readAddrB(readAddrB),
        .aluOp(aluOp),
        .immediate(immediate),
        .useImmediate(useImmediate),
        .regWrite(regWrite),
        .writeAddr(writeAddr),
        .flagsWrite(flagsWrite),
        .carryCmd(carryCmd)
    );

endmodule

`default_nettype wire

// File: tests/z8SocTb.sv
`timescale 1ns/1ps
`default_nettype none

module z8SocTb;

    localparam int numRows = 9;
    localparam int quietCycles = 80;

    // byte 0 of each program sits in the top byte, unused bytes are nop
    localparam logic [127:0] programs [numRows] = '{
        128'h2C55_FFE6_02A3_E6E2_3C8B_FEFF_FFFF_FFFF,
        128'hE6FC_807B_022C_11FB_022C_228B_FEFF_FFFF,
        128'h2C5A_4CC3_0224_1224_1224_7224_8BFE_FFFF,
        128'h2C30_4C45_2224_3224_3224_8BFE_FFFF_FFFF,
        128'h2C5C_4C3A_4224_5224_B224_6224_A224_8BFE,
        128'hA201_6D00_072C_112C_A17D_000E_2CA2_8BFE,
        128'h3C10_4C20_A234_1B02_2C11_9B02_2CB2_8BFE,
        128'h2C7F_2E4B_022C_112E_CB02_2C11_8BFE_FFFF,
        128'hDF12_23EF_1223_DFCF_1223_EF12_238B_FEFF
    };

    localparam int progLengths [numRows] = '{11, 13, 14, 12, 16, 16, 16, 14, 15};

    // port 2 values in write order, first one in the top byte
    localparam logic [31:0] expected [numRows] = '{
        32'h55A3_3C00,
        32'h2200_0000,
        32'h5A1D_E1A4,
        32'h30EB_A560,
        32'h5C7E_3A00,
        32'hA1A2_0000,
        32'hB200_0000,
        32'h7F80_8100,
        32'h0102_0203
    };

    localparam int expCounts [numRows] = '{3, 1, 4, 4, 4, 2, 1, 3, 4};

    logic        clk;
    logic        rst;
    logic        loadWrite;
    logic [7:0]  loadAddr;
    z8Pkg::byteT loadData;
    z8Pkg::byteT port2;
    logic        port2Write;

    z8Soc #(
        .romAddrWidth(8)
    ) u_z8Soc (
        .clk(clk),
        .rst(rst),
        .loadWrite(loadWrite),
        .loadAddr(loadAddr),
        .loadData(loadData),
        .port2(port2),
        .port2Write(port2Write)
    );

    always #5 clk = ~clk;

    task automatic checkByte(input string name, input z8Pkg::byteT actual,
                             input z8Pkg::byteT want);
        if (actual !== want) begin
            $display("Fail at %0t ns: %s = %h, expected %h", $time, name, actual, want);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    task automatic checkCount(input string name, input int actual, input int want);
        if (actual != want) begin
            $display("Fail at %0t ns: %s = %0d, expected %0d", $time, name, actual, want);
            $display("tests failed");
            $fatal(1);
        end
    endtask

    // one byte per clock while the core sits in reset
    task automatic loadProgram(input int row);
        int i;
        for (i = 0; i < progLengths[row]; i++) begin
            loadWrite = 1'b1;
            loadAddr = 8'(i);
            loadData = programs[row][8*(15-i) +: 8];
            @(negedge clk);
        end
        loadWrite = 1'b0;
    endtask

    task automatic runRow(input int row);
        z8Pkg::byteT want;
        int seen;
        int k;
        @(negedge clk);
        rst = 1'b1;
        repeat (3) @(negedge clk);
        loadProgram(row);
        rst = 1'b0;
        seen = 0;
        for (k = 0; k < expCounts[row]; k++) begin
            want = expected[row][8*(3-k) +: 8];
            @(negedge clk);
            while (!port2Write) begin
                @(negedge clk);
            end
            // new value shows on port2 one cycle after the strobe
            @(negedge clk);
            checkByte($sformatf("port2 (row %0d, write %0d)", row, k), port2, want);
            seen++;
        end
        // program should now spin on its final jr
        repeat (quietCycles) begin
            @(negedge clk);
            if (port2Write) begin
                seen++;
            end
        end
        checkCount($sformatf("port2Write count (row %0d)", row), seen, expCounts[row]);
    endtask

    initial begin
        int row;
        clk = 1'b0;
        rst = 1'b1;
        loadWrite = 1'b0;
        loadAddr = '0;
        loadData = '0;
        for (row = 0; row < numRows; row++) begin
            runRow(row);
        end
        $display("all tests passed");
        $finish;
    end

    // generous bound per table row
    initial begin
        repeat (numRows * 200) @(posedge clk);
        $display("Timeout: the core hung, port 2 writes stopped before the table was done");
        $display("tests failed");
        $fatal(1);
    end

endmodule

`default_nettype wire

// File: sources.f
hw/z8Pkg.sv
hw/programMemory.sv
hw/fetchUnit.sv
hw/registerFile.sv
hw/alu.sv
hw/sequencer.sv
hw/z8Soc.sv
tests/z8SocTb.sv

// File: Makefile
.PHONY: all lint clean

all:
	verilator --binary --top-module z8SocTb -f sources.f
	@out=$$(./obj_dir/Vz8SocTb); echo "$$out"; echo "$$out" | grep -q "all tests passed"

lint:
	verilator --lint-only --timing --top-module z8SocTb -f sources.f

clean:
	rm -rf obj_dir
